/* src/bridge_pkg.sv */
package bridge_pkg;

  typedef logic [7:0]  byte_t;      // uart byte, register value or pin port
  typedef logic [7:0]  cmd_t;
  typedef logic [23:0] mem_addr_t;  // word address
  typedef logic [15:0] mem_data_t;
  typedef logic [63:0] pin_bus_t;   // port n in byte n

  // uart bit timing
  localparam int CLKS_PER_BIT = 8;
  localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);

  typedef logic [BAUD_CNT_W-1:0] baud_cnt_t;

  localparam baud_cnt_t BAUD_LAST = baud_cnt_t'(CLKS_PER_BIT - 1);
  localparam baud_cnt_t BAUD_HALF = baud_cnt_t'(CLKS_PER_BIT / 2 - 1);  // mid start bit

  // single commands
  localparam cmd_t CMD_NONE    = 8'h00;
  localparam cmd_t CMD_CLK_SET = 8'h10;
  localparam cmd_t CMD_CLK_CLR = 8'h11;
  localparam cmd_t CMD_RST_SET = 8'h12;
  localparam cmd_t CMD_RST_CLR = 8'h13;
  localparam cmd_t CMD_MEM_WR  = 8'hA0;
  localparam cmd_t CMD_MEM_RD  = 8'hA1;

  // group bases, low three bits pick the port or register
  localparam cmd_t CMD_PIN_RD  = 8'h20;
  localparam cmd_t CMD_PIN_WR  = 8'h30;
  localparam cmd_t CMD_UREG_WR = 8'h40;
  localparam cmd_t CMD_UREG_RD = 8'h50;
  localparam cmd_t CMD_PIN_REL = 8'h60;

  localparam byte_t LAT_MAX = 8'hFF;  // latency saturation

  typedef enum logic [1:0] {
    RX_IDLE, RX_START, RX_DATA, RX_STOP
  } rx_state_t;

  typedef enum logic [1:0] {
    TX_IDLE, TX_START, TX_DATA, TX_STOP
  } tx_state_t;

  typedef enum logic [1:0] {
    MEM_IDLE, MEM_WAIT_ACK, MEM_WAIT_RELEASE
  } mem_state_t;

endpackage

/* src/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx (
  input  logic              sys_clk,
  input  logic              sys_rst_n,
  input  logic              rxd,
  output logic              rx_valid,
  output bridge_pkg::byte_t rx_data
);

  import bridge_pkg::*;

  logic      rxd_meta;
  logic      rxd_sync;
  rx_state_t state;
  baud_cnt_t clk_cnt;
  logic [2:0] bit_idx;
  byte_t     shift;

  // two flop synchroniser, line idles high
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state    <= RX_IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      shift    <= '0;
      rx_valid <= 1'b0;
      rx_data  <= '0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          clk_cnt <= '0;
          if (!rxd_sync) state <= RX_START;
        end
        RX_START: begin
          if (clk_cnt == BAUD_HALF) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= rxd_sync ? RX_IDLE : RX_DATA;  // glitch, not a start bit
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (clk_cnt == BAUD_LAST) begin
            clk_cnt <= '0;
            shift   <= {rxd_sync, shift[7:1]};  // lsb first
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= RX_STOP;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (clk_cnt == BAUD_LAST) begin
            state <= RX_IDLE;
            if (rxd_sync) begin  // bad stop bit drops the frame
              rx_valid <= 1'b1;
              rx_data  <= shift;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

endmodule

/* src/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx (
  input  logic              sys_clk,
  input  logic              sys_rst_n,
  input  logic              tx_start,
  input  bridge_pkg::byte_t tx_data,
  output logic              txd,
  output logic              tx_busy
);

  import bridge_pkg::*;

  tx_state_t  state;
  baud_cnt_t  clk_cnt;
  logic [2:0] bit_idx;
  byte_t      shift;

  assign tx_busy = (state != TX_IDLE);  // through the end of the stop bit

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state   <= TX_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      shift   <= '0;
      txd     <= 1'b1;
    end else begin
      case (state)
        TX_IDLE: begin
          txd     <= 1'b1;
          clk_cnt <= '0;
          if (tx_start) begin
            shift <= tx_data;
            txd   <= 1'b0;  // start bit
            state <= TX_START;
          end
        end
        TX_START: begin
          if (clk_cnt == BAUD_LAST) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            txd     <= shift[0];
            shift   <= shift >> 1;
            state   <= TX_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        TX_DATA: begin
          if (clk_cnt == BAUD_LAST) begin
            clk_cnt <= '0;
            if (bit_idx == 3'd7) begin
              txd   <= 1'b1;  // stop bit
              state <= TX_STOP;
            end else begin
              txd     <= shift[0];
              shift   <= shift >> 1;
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        TX_STOP: begin
          if (clk_cnt == BAUD_LAST) state <= TX_IDLE;
          else clk_cnt <= clk_cnt + 1'b1;
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

endmodule

/* src/cmd_framer.sv */
`timescale 1ns/1ns

module cmd_framer (
  input  logic              sys_clk,
  input  logic              sys_rst_n,
  input  logic              rx_valid,
  input  bridge_pkg::byte_t rx_data,
  input  logic              cmd_done,
  output bridge_pkg::cmd_t  cmd,
  output logic              data_valid,
  output bridge_pkg::byte_t data_byte,
  output logic              busy
);

  import bridge_pkg::*;

  logic pending;

  assign pending = (cmd != CMD_NONE);
  assign busy    = pending;  // from cmd set until it clears

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      cmd        <= CMD_NONE;
      data_valid <= 1'b0;
      data_byte  <= '0;
    end else begin
      data_valid <= 1'b0;

      // first byte after idle is the command, a 00h byte leaves it idle
      if (cmd_done) begin
        cmd <= CMD_NONE;
      end else if (rx_valid && !pending) begin
        cmd <= rx_data;
      end

      // later bytes are argument bytes for the pending command
      if (rx_valid && pending) begin
        data_valid <= 1'b1;
        data_byte  <= rx_data;
      end
    end
  end

  // a byte landing on the cmd_done cycle goes out as data with no
  // command behind it, so the executor never sees it

endmodule

/* src/cmd_exec.sv */
`timescale 1ns/1ns

module cmd_exec (
  input  logic                  sys_clk,
  input  logic                  sys_rst_n,
  input  bridge_pkg::cmd_t      cmd,
  input  logic                  data_valid,
  input  bridge_pkg::byte_t     data_byte,
  output logic                  cmd_done,
  output logic                  tx_start,
  output bridge_pkg::byte_t     tx_data,
  input  logic                  tx_busy,
  input  bridge_pkg::pin_bus_t  in_pin,
  output bridge_pkg::pin_bus_t  out_pin,
  output bridge_pkg::byte_t     pin_oe,
  output logic                  out_clk,
  output logic                  out_rst,
  output logic                  mem_start,
  output logic                  mem_write,
  output bridge_pkg::mem_addr_t mem_addr_in,
  output bridge_pkg::mem_data_t mem_wdata_in,
  input  logic                  mem_finish,
  input  bridge_pkg::mem_data_t mem_rdata,
  input  bridge_pkg::byte_t     mem_cycles
);

  import bridge_pkg::*;

  byte_t      wreg [8];  // host write registers
  byte_t      rreg0;
  byte_t      rreg1;
  byte_t      rreg7;     // last access latency
  logic       mem_pending;
  logic [4:0] grp;
  logic [2:0] idx;
  logic       is_pin_rd;
  logic       is_pin_wr;
  logic       is_pin_rel;
  logic       is_ureg_wr;
  logic       is_ureg_rd;
  logic       is_mem;
  byte_t      rreg_sel;
  byte_t      reply_byte;

  assign grp = cmd[7:3];
  assign idx = cmd[2:0];

  assign is_pin_rd  = (grp == CMD_PIN_RD[7:3]);
  assign is_pin_wr  = (grp == CMD_PIN_WR[7:3]);
  assign is_pin_rel = (grp == CMD_PIN_REL[7:3]);
  assign is_ureg_wr = (grp == CMD_UREG_WR[7:3]);
  assign is_ureg_rd = (grp == CMD_UREG_RD[7:3]);
  assign is_mem     = (cmd == CMD_MEM_WR) || (cmd == CMD_MEM_RD);

  // address from wreg 4..2, data from wreg 1..0
  assign mem_addr_in  = {wreg[4], wreg[3], wreg[2]};
  assign mem_wdata_in = {wreg[1], wreg[0]};
  assign mem_write    = (cmd == CMD_MEM_WR);

  always_comb begin
    case (idx)
      3'd0:    rreg_sel = rreg0;
      3'd1:    rreg_sel = rreg1;
      3'd7:    rreg_sel = rreg7;
      default: rreg_sel = '0;  // 2 to 6 read zero
    endcase
  end

  assign reply_byte = is_pin_rd ? in_pin[{idx, 3'b000} +: 8] : rreg_sel;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      cmd_done    <= 1'b0;
      tx_start    <= 1'b0;
      tx_data     <= '0;
      out_pin     <= '0;
      pin_oe      <= '0;
      out_clk     <= 1'b0;
      out_rst     <= 1'b0;
      mem_start   <= 1'b0;
      mem_pending <= 1'b0;
      rreg0       <= '0;
      rreg1       <= '0;
      rreg7       <= '0;
      for (int i = 0; i < 8; i++) wreg[i] <= '0;
    end else begin
      cmd_done  <= 1'b0;
      tx_start  <= 1'b0;
      mem_start <= 1'b0;

      // skip the cycle where the framer is still clearing cmd
      if (!cmd_done && cmd != CMD_NONE) begin
        if (is_mem) begin
          if (!mem_pending) begin  // issue once, then wait
            mem_start   <= 1'b1;
            mem_pending <= 1'b1;
          end else if (mem_finish) begin
            mem_pending <= 1'b0;
            rreg7       <= mem_cycles;
            cmd_done    <= 1'b1;
            if (cmd == CMD_MEM_RD) begin
              rreg0 <= mem_rdata[7:0];
              rreg1 <= mem_rdata[15:8];
            end
          end
        end else if (is_pin_rd || is_ureg_rd) begin
          if (!tx_busy) begin  // hold off while a reply is going out
            tx_start <= 1'b1;
            tx_data  <= reply_byte;
            cmd_done <= 1'b1;
          end
        end else if (is_pin_wr || is_ureg_wr) begin
          if (data_valid) begin
            if (is_pin_wr) begin
              out_pin[{idx, 3'b000} +: 8] <= data_byte;
              pin_oe[idx]                 <= 1'b1;
            end else begin
              wreg[idx] <= data_byte;
            end
            cmd_done <= 1'b1;
          end
        end else begin
          // strobes, release, and anything unknown finish at once
          case (cmd)
            CMD_CLK_SET: out_clk <= 1'b1;
            CMD_CLK_CLR: out_clk <= 1'b0;
            CMD_RST_SET: out_rst <= 1'b1;
            CMD_RST_CLR: out_rst <= 1'b0;
            default:     ;
          endcase
          if (is_pin_rel) pin_oe[idx] <= 1'b0;  // back to high-z
          cmd_done <= 1'b1;
        end
      end
    end
  end

endmodule

/* src/mem_access.sv */
`timescale 1ns/1ns

module mem_access (
  input  logic                  sys_clk,
  input  logic                  sys_rst_n,
  input  logic                  mem_start,
  input  logic                  mem_write,
  input  bridge_pkg::mem_addr_t mem_addr_in,
  input  bridge_pkg::mem_data_t mem_wdata_in,
  output logic                  mem_finish,
  output bridge_pkg::mem_data_t mem_rdata,
  output bridge_pkg::byte_t     mem_cycles,
  output logic                  mem_req,
  output logic                  mem_we,
  output bridge_pkg::mem_addr_t mem_addr,
  output bridge_pkg::mem_data_t mem_wdata,
  input  logic                  mem_ack,
  input  bridge_pkg::mem_data_t mem_rdata_ext
);

  import bridge_pkg::*;

  mem_state_t state;
  byte_t      lat_cnt;
  byte_t      lat_next;

  assign lat_next = (lat_cnt == LAT_MAX) ? lat_cnt : lat_cnt + 1'b1;  // saturate

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state      <= MEM_IDLE;
      mem_req    <= 1'b0;
      mem_we     <= 1'b0;
      mem_addr   <= '0;
      mem_wdata  <= '0;
      mem_rdata  <= '0;
      mem_cycles <= '0;
      mem_finish <= 1'b0;
      lat_cnt    <= '0;
    end else begin
      mem_finish <= 1'b0;
      case (state)
        MEM_IDLE: if (mem_start) begin
          mem_req   <= 1'b1;  // addr and data stable with req
          mem_we    <= mem_write;
          mem_addr  <= mem_addr_in;
          mem_wdata <= mem_wdata_in;
          lat_cnt   <= '0;
          state     <= MEM_WAIT_ACK;
        end
        MEM_WAIT_ACK: begin
          lat_cnt <= lat_next;
          if (mem_ack) begin
            mem_req    <= 1'b0;
            mem_rdata  <= mem_rdata_ext;
            mem_cycles <= lat_next;
            state      <= MEM_WAIT_RELEASE;
          end
        end
        MEM_WAIT_RELEASE: if (!mem_ack) begin  // memory side done
          mem_we     <= 1'b0;
          mem_finish <= 1'b1;
          state      <= MEM_IDLE;
        end
        default: state <= MEM_IDLE;
      endcase
    end
  end

endmodule

/* src/pin_bridge_top.sv */
`timescale 1ns/1ns

module pin_bridge_top (
  input  logic                  sys_clk,
  input  logic                  sys_rst_n,
  input  logic                  rxd,
  output logic                  txd,
  output logic                  busy,
  input  bridge_pkg::pin_bus_t  in_pin,
  output bridge_pkg::pin_bus_t  out_pin,
  output bridge_pkg::byte_t     pin_oe,
  output logic                  out_clk,
  output logic                  out_rst,
  output logic                  mem_req,
  output logic                  mem_we,
  output bridge_pkg::mem_addr_t mem_addr,
  output bridge_pkg::mem_data_t mem_wdata,
  input  logic                  mem_ack,
  input  bridge_pkg::mem_data_t mem_rdata_ext
);

  import bridge_pkg::*;

  logic      rx_valid;
  byte_t     rx_data;
  cmd_t      cmd;
  logic      data_valid;
  byte_t     data_byte;
  logic      cmd_done;
  logic      tx_start;
  byte_t     tx_data;
  logic      tx_busy;
  logic      mem_start;
  logic      mem_write;
  mem_addr_t mem_addr_in;
  mem_data_t mem_wdata_in;
  logic      mem_finish;
  mem_data_t mem_rdata;
  byte_t     mem_cycles;

  uart_rx u_uart_rx (.sys_clk, .sys_rst_n, .rxd, .rx_valid, .rx_data);

  uart_tx u_uart_tx (.sys_clk, .sys_rst_n, .tx_start, .tx_data, .txd, .tx_busy);

  cmd_framer u_cmd_framer (
    .sys_clk, .sys_rst_n, .rx_valid, .rx_data, .cmd_done,
    .cmd, .data_valid, .data_byte, .busy
  );

  cmd_exec u_cmd_exec (
    .sys_clk, .sys_rst_n, .cmd, .data_valid, .data_byte, .cmd_done,
    .tx_start, .tx_data, .tx_busy,
    .in_pin, .out_pin, .pin_oe, .out_clk, .out_rst,
    .mem_start, .mem_write, .mem_addr_in, .mem_wdata_in,
    .mem_finish, .mem_rdata, .mem_cycles
  );

  // four-phase port to the external memory
  mem_access u_mem_access (
    .sys_clk, .sys_rst_n, .mem_start, .mem_write, .mem_addr_in, .mem_wdata_in,
    .mem_finish, .mem_rdata, .mem_cycles,
    .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata_ext
  );

endmodule

/* bench/bridge_asserts.sv */
`timescale 1ns/1ns

module bridge_asserts (
  input logic sys_clk,
  input logic sys_rst_n,
  input logic mem_req,
  input logic mem_ack,
  input logic cmd_done,
  input logic busy
);

  // request held until the memory answers
  a_req_hold: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    mem_req && !mem_ack |=> mem_req)
    else $error("mem_req dropped before mem_ack");

  a_req_after_release: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    $rose(mem_req) |-> !mem_ack)
    else $error("mem_req raised while mem_ack still high");

  // done only while a command is pending and busy drops on the next cycle
  a_idle_after_done: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    cmd_done |-> busy ##1 !busy)
    else $error("cmd_done without a pending command or busy still high after it");

endmodule

// unused inputs tied off on each target
bind mem_access bridge_asserts u_mem_asserts (
  .sys_clk, .sys_rst_n, .mem_req, .mem_ack, .cmd_done(1'b0), .busy(1'b0)
);

bind cmd_framer bridge_asserts u_framer_asserts (
  .sys_clk, .sys_rst_n, .mem_req(1'b0), .mem_ack(1'b0), .cmd_done, .busy
);

/* bench/tb_top.sv */
`timescale 1ns/1ns

module tb_top;

  import bridge_pkg::*;

  localparam int NUM_TESTS   = 6;
  localparam int WATCHDOG_NS = NUM_TESTS * 40 * 10 * CLKS_PER_BIT * 40;
  localparam int FRAME_WAIT  = 40 * CLKS_PER_BIT;  // cycles before a reply must start
  localparam int DONE_WAIT   = 20 * CLKS_PER_BIT;

  logic        sys_clk;
  logic        sys_rst_n;
  logic        rxd;
  logic        txd;
  logic        busy;
  pin_bus_t    in_pin;
  pin_bus_t    out_pin;
  byte_t       pin_oe;
  logic        out_clk;
  logic        out_rst;
  logic        mem_req;
  logic        mem_we;
  mem_addr_t   mem_addr;
  mem_data_t   mem_wdata;
  logic        mem_ack;
  mem_data_t   mem_rdata_ext;

  mem_data_t   mem_model [256];
  mem_addr_t   last_addr;
  int          last_lat;
  logic [31:0] lfsr = 32'hc08b82a6;
  int          value_errs;
  int          other_errs;
  int          done_cnt = 0;    // falling edges of busy
  logic        busy_q   = 1'b0;

  pin_bridge_top DUT (.*);

  initial sys_clk = 1'b0;
  always #20 sys_clk = ~sys_clk;

  always @(negedge sys_clk) begin
    busy_q <= busy;
    if (busy_q && !busy) done_cnt <= done_cnt + 1;
  end

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_word(input string name, input mem_data_t exp, input mem_data_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_addr(input string name, input mem_addr_t exp, input mem_addr_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  // host side uart, called on a falling edge
  task automatic send_byte(input byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rxd = frame[i];
      repeat (CLKS_PER_BIT) @(negedge sys_clk);
    end
  endtask

  task automatic recv_byte(input string name, output byte_t b);
    int wait_cnt;
    wait_cnt = 0;
    b        = '0;
    while (txd && wait_cnt < FRAME_WAIT) begin
      @(negedge sys_clk);
      wait_cnt++;
    end
    if (txd) begin
      $display("%s: no reply frame appeared on txd", name);
      other_errs++;
    end else begin
      repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);  // middle of start bit
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge sys_clk);
        b[i] = txd;
      end
      repeat (CLKS_PER_BIT) @(negedge sys_clk);
      if (!txd) begin
        $display("%s: reply frame has a bad stop bit", name);
        other_errs++;
      end
    end
  endtask

  // command without reply, waits for busy to fall
  task automatic issue(input string name, input cmd_t c, input logic has_data, input byte_t d);
    int target;
    int wait_cnt;
    target   = done_cnt + 1;
    wait_cnt = 0;
    send_byte(c);
    if (has_data) send_byte(d);
    while (done_cnt < target && wait_cnt < DONE_WAIT) begin
      @(negedge sys_clk);
      wait_cnt++;
    end
    if (done_cnt < target) begin
      $display("%s: command %h never completed", name, c);
      other_errs++;
    end
    check_byte({name, " busy"}, 8'h00, {7'b0, busy});
  endtask

  task automatic query(input string name, input cmd_t c, output byte_t b);
    fork
      send_byte(c);
      recv_byte(name, b);
    join
  endtask

  task automatic strobes_toggle();
    issue("clk set", CMD_CLK_SET, 1'b0, 8'h00);
    check_byte("clk set clk", 8'h01, {7'b0, out_clk});
    check_byte("clk set rst", 8'h00, {7'b0, out_rst});
    issue("rst set", CMD_RST_SET, 1'b0, 8'h00);
    check_byte("clk high", 8'h01, {7'b0, out_clk});
    check_byte("rst high", 8'h01, {7'b0, out_rst});
    issue("clk clear", CMD_CLK_CLR, 1'b0, 8'h00);
    check_byte("clk clear clk", 8'h00, {7'b0, out_clk});
    check_byte("clk clear rst", 8'h01, {7'b0, out_rst});
    issue("rst clear", CMD_RST_CLR, 1'b0, 8'h00);
    check_byte("clk low", 8'h00, {7'b0, out_clk});
    check_byte("rst low", 8'h00, {7'b0, out_rst});
  endtask

  task automatic pins_drive_release();
    pin_bus_t exp_pin;
    byte_t    exp_oe;
    byte_t    d;
    exp_pin = '0;
    exp_oe  = '0;
    for (int x = 0; x < 8; x++) begin
      d = byte_t'(rand_bits(8));
      issue("pin drive", CMD_PIN_WR | cmd_t'(x), 1'b1, d);
      exp_pin[x*8 +: 8] = d;
      exp_oe[x]         = 1'b1;
      check_byte("pin drive value", exp_pin[x*8 +: 8], out_pin[x*8 +: 8]);
      check_byte("pin drive oe", exp_oe, pin_oe);
    end
    issue("pin release", CMD_PIN_REL | 8'h02, 1'b0, 8'h00);
    exp_oe[2] = 1'b0;
    check_byte("pin release oe", exp_oe, pin_oe);
    issue("pin release", CMD_PIN_REL | 8'h05, 1'b0, 8'h00);
    exp_oe[5] = 1'b0;
    check_byte("pin release oe", exp_oe, pin_oe);
    for (int x = 0; x < 8; x++) begin
      check_byte("pin hold value", exp_pin[x*8 +: 8], out_pin[x*8 +: 8]);
    end
  endtask

  task automatic pins_sample();
    byte_t got;
    in_pin = {rand_bits(32), rand_bits(32)};
    for (int x = 0; x < 8; x++) begin
      query("pin sample", CMD_PIN_RD | cmd_t'(x), got);
      check_byte("pin sample", in_pin[x*8 +: 8], got);
    end
  endtask

  task automatic regs_echo();
    byte_t got;
    byte_t first;
    byte_t second;
    for (int x = 0; x < 8; x++) begin
      issue("reg write", CMD_UREG_WR | cmd_t'(x), 1'b1, byte_t'(rand_bits(8)));
    end
    for (int x = 2; x < 7; x++) begin
      query("reg read zero", CMD_UREG_RD | cmd_t'(x), got);
      check_byte("reg read zero", 8'h00, got);
    end
    // second command lands while the first reply is on the line
    fork
      begin
        send_byte(CMD_UREG_RD | 8'h03);
        send_byte(CMD_PIN_RD | 8'h06);
      end
      begin
        recv_byte("back to back first", first);
        recv_byte("back to back second", second);
      end
    join
    check_byte("back to back first", 8'h00, first);
    check_byte("back to back second", in_pin[55:48], second);
  endtask

  task automatic mem_round_trip();
    mem_addr_t addr;
    mem_data_t wdata;
    mem_data_t rdata;
    byte_t     lo;
    byte_t     hi;
    byte_t     lat;
    addr  = mem_addr_t'(rand_bits(24));
    wdata = mem_data_t'(rand_bits(16));
    issue("mem addr low", CMD_UREG_WR | 8'h02, 1'b1, addr[7:0]);
    issue("mem addr mid", CMD_UREG_WR | 8'h03, 1'b1, addr[15:8]);
    issue("mem addr high", CMD_UREG_WR | 8'h04, 1'b1, addr[23:16]);
    issue("mem data low", CMD_UREG_WR, 1'b1, wdata[7:0]);
    issue("mem data high", CMD_UREG_WR | 8'h01, 1'b1, wdata[15:8]);
    issue("mem write", CMD_MEM_WR, 1'b0, 8'h00);
    check_addr("mem write addr", addr, last_addr);
    check_word("mem write", wdata, mem_model[addr[7:0]]);
    rdata                = ~wdata;  // word changed behind the bridge
    mem_model[addr[7:0]] = rdata;
    issue("mem read", CMD_MEM_RD, 1'b0, 8'h00);
    query("mem read low", CMD_UREG_RD, lo);
    query("mem read high", CMD_UREG_RD | 8'h01, hi);
    check_word("mem read", rdata, {hi, lo});
    query("mem latency", CMD_UREG_RD | 8'h07, lat);
    check_byte("mem latency", byte_t'(last_lat), lat);
    if (lat < 8'd1 || lat > 8'd8) begin
      $display("memory latency %0d is outside 1 to 8 cycles", lat);
      other_errs++;
    end
  endtask

  task automatic unknown_cmd_ignored();
    pin_bus_t pin_before;
    byte_t    oe_before;
    byte_t    got;
    pin_before = out_pin;
    oe_before  = pin_oe;
    issue("unknown cmd", 8'h7F, 1'b0, 8'h00);
    check_byte("unknown no reply", 8'h01, {7'b0, txd});  // a reply would be in its start bit
    check_byte("unknown oe", oe_before, pin_oe);
    for (int x = 0; x < 8; x++) begin
      check_byte("unknown pin", pin_before[x*8 +: 8], out_pin[x*8 +: 8]);
    end
    query("after unknown", CMD_PIN_RD | 8'h01, got);
    check_byte("after unknown", in_pin[15:8], got);
  endtask

  // memory model with 1 to 8 cycle latency
  initial begin
    mem_ack       = 1'b0;
    mem_rdata_ext = '0;
    last_addr     = '0;
    last_lat      = 0;
    for (int i = 0; i < 256; i++) mem_model[i] = {8'(i), ~8'(i)};
    forever begin
      @(negedge sys_clk);
      if (sys_rst_n && mem_req && !mem_ack) begin
        last_lat  = 1 + int'(rand_bits(3));
        last_addr = mem_addr;
        repeat (last_lat - 1) @(negedge sys_clk);
        if (mem_we) mem_model[mem_addr[7:0]] = mem_wdata;
        else mem_rdata_ext = mem_model[mem_addr[7:0]];
        mem_ack = 1'b1;  // read data valid with ack
        while (mem_req) @(negedge sys_clk);
        mem_ack = 1'b0;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    value_errs = 0;
    other_errs = 0;
    sys_rst_n  = 1'b0;
    rxd        = 1'b1;
    in_pin     = '0;
    repeat (3) @(negedge sys_clk);
    sys_rst_n = 1'b1;
    check_byte("reset txd", 8'h01, {7'b0, txd});
    check_byte("reset busy", 8'h00, {7'b0, busy});
    check_byte("reset mem_req", 8'h00, {7'b0, mem_req});
    check_byte("reset pin_oe", 8'h00, pin_oe);
    strobes_toggle();
    pins_drive_release();
    pins_sample();
    regs_echo();
    mem_round_trip();
    unknown_cmd_ignored();
    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) $display("Simulation PASSED");
    else $display("Simulation FAILED");
    $finish;
  end

endmodule

/* verilog.f */
src/bridge_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/cmd_framer.sv
src/cmd_exec.sv
src/mem_access.sv
src/pin_bridge_top.sv
bench/bridge_asserts.sv
bench/tb_top.sv

/* run.sh */
#!/bin/sh
# build and run the bridge testbench with verilator, pass decided from the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -f verilog.f --top-module tb_top \
  -Mdir obj_dir -o tb_top \
  && ./obj_dir/tb_top > "$LOG" 2>&1 \
  ; cat "$LOG" 2>/dev/null \
  ; grep -q "Simulation PASSED" "$LOG" \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
